// ==== src/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Written by every link instruction
    localparam reg_addr_t link_reg = 5'd31;

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LWL     = 6'b100010,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_LWR     = 6'b100110,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SWL     = 6'b101010,
        OP_SW      = 6'b101011,
        OP_SWR     = 6'b101110,
        OP_LL      = 6'b110000,
        OP_PREF    = 6'b110011,
        OP_SC      = 6'b111000
    } opcode_t;

    // SPECIAL function field, instr[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_JR   = 6'b001000,
        F_JALR = 6'b001001,
        F_SYNC = 6'b001111,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_t;

    // REGIMM rt field, instr[20:16]
    typedef enum logic [4:0] {
        B_BLTZ   = 5'b00000,
        B_BGEZ   = 5'b00001,
        B_BLTZAL = 5'b10000,
        B_BGEZAL = 5'b10001
    } regimm_t;

    // NOP must stay at zero, it is the reset value
    typedef enum logic [5:0] {
        NOP = 6'd0,
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        JR, JALR,
        ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
        BEQ, BNE, BGTZ, BLEZ, BGEZ, BLTZ, BGEZAL, BLTZAL,
        J, JAL,
        LB, LBU, LH, LHU, LW, LWL, LWR,
        SB, SH, SW, SWL, SWR,
        RESERVED
    } decoded_op_t;

    typedef enum logic [3:0] {
        ALU_NONE  = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_ADDU  = 4'd2,
        ALU_SUB   = 4'd3,
        ALU_SUBU  = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_SLTU  = 4'd6,
        ALU_AND   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_XOR   = 4'd9,
        ALU_NOR   = 4'd10,
        ALU_SLL   = 4'd11,
        ALU_SRL   = 4'd12,
        ALU_SRA   = 4'd13,
        ALU_LUI   = 4'd14,
        ALU_PASSA = 4'd15
    } alu_func_t;

    typedef enum logic {
        REGB = 1'b0,
        IMM  = 1'b1
    } alu_src_t;

    typedef enum logic [2:0] {
        T_NONE = 3'd0,
        T_BEQ  = 3'd1,
        T_BNE  = 3'd2,
        T_BGEZ = 3'd3,
        T_BLTZ = 3'd4,
        T_BGTZ = 3'd5,
        T_BLEZ = 3'd6
    } branch_type_t;

endpackage

// ==== src/op_decode.sv ====
`timescale 1ns/1ns

module op_decode (
    input  mips_pkg::word_t       instr,
    output mips_pkg::decoded_op_t op,
    output logic                  reserved
);
    import mips_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    regimm_t regimm;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign regimm = regimm_t'(instr[20:16]);

    always_comb begin
        op = RESERVED;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    F_ADD:   op = ADD;
                    F_ADDU:  op = ADDU;
                    F_SUB:   op = SUB;
                    F_SUBU:  op = SUBU;
                    F_SLT:   op = SLT;
                    F_SLTU:  op = SLTU;
                    F_AND:   op = AND;
                    F_OR:    op = OR;
                    F_XOR:   op = XOR;
                    F_NOR:   op = NOR;
                    F_SLL:   op = SLL;
                    F_SRL:   op = SRL;
                    F_SRA:   op = SRA;
                    F_SLLV:  op = SLLV;
                    F_SRLV:  op = SRLV;
                    F_SRAV:  op = SRAV;
                    F_JR:    op = JR;
                    F_JALR:  op = JALR;
                    // No memory ordering to enforce here
                    F_SYNC:  op = NOP;
                    default: op = RESERVED;
                endcase
            end
            OP_REGIMM: begin
                case (regimm)
                    B_BGEZ:   op = BGEZ;
                    B_BLTZ:   op = BLTZ;
                    B_BGEZAL: op = BGEZAL;
                    B_BLTZAL: op = BLTZAL;
                    default:  op = RESERVED;
                endcase
            end
            OP_J:     op = J;
            OP_JAL:   op = JAL;
            OP_BEQ:   op = BEQ;
            OP_BNE:   op = BNE;
            OP_BLEZ:  op = BLEZ;
            OP_BGTZ:  op = BGTZ;

            OP_ADDI:  op = ADDI;
            OP_ADDIU: op = ADDIU;
            OP_SLTI:  op = SLTI;
            OP_SLTIU: op = SLTIU;
            OP_ANDI:  op = ANDI;
            OP_ORI:   op = ORI;
            OP_XORI:  op = XORI;
            OP_LUI:   op = LUI;

            OP_LB:    op = LB;
            OP_LBU:   op = LBU;
            OP_LH:    op = LH;
            OP_LHU:   op = LHU;
            OP_LW:    op = LW;
            OP_LWL:   op = LWL;
            OP_LWR:   op = LWR;
            OP_SB:    op = SB;
            OP_SH:    op = SH;
            OP_SW:    op = SW;
            OP_SWL:   op = SWL;
            OP_SWR:   op = SWR;

            // Single core, no link bit to track
            OP_LL:    op = LW;
            OP_SC:    op = SW;
            // Prefetch is only a hint
            OP_PREF:  op = NOP;

            default:  op = RESERVED;
        endcase
    end

    assign reserved = (op == RESERVED);

endmodule

// ==== src/control_gen.sv ====
`timescale 1ns/1ns

module control_gen (
    input  mips_pkg::decoded_op_t  op,
    output logic                   regwrite,
    output logic                   memtoreg,
    output logic                   memwrite,
    output logic                   zeroext,
    output logic                   shamt_valid,
    output logic                   branch,
    output logic                   jump,
    output logic                   jr,
    output logic                   is_link,
    output mips_pkg::alu_src_t     alusrc,
    output mips_pkg::alu_func_t    alufunc,
    output mips_pkg::branch_type_t branch_type
);
    import mips_pkg::*;

    // Enables and operand source
    always_comb begin
        regwrite    = 1'b0;
        memtoreg    = 1'b0;
        memwrite    = 1'b0;
        zeroext     = 1'b0;
        shamt_valid = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        jr          = 1'b0;
        is_link     = 1'b0;
        alusrc      = REGB;
        case (op)
            ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR,
            SLLV, SRLV, SRAV: begin
                regwrite = 1'b1;
            end
            SLL, SRL, SRA: begin
                regwrite    = 1'b1;
                shamt_valid = 1'b1;
            end
            ADDI, ADDIU, SLTI, SLTIU, LUI: begin
                regwrite = 1'b1;
                alusrc   = IMM;
            end
            ANDI, ORI, XORI: begin
                regwrite = 1'b1;
                alusrc   = IMM;
                zeroext  = 1'b1;
            end
            BEQ, BNE, BGEZ, BLTZ, BGTZ, BLEZ: begin
                branch = 1'b1;
            end
            BGEZAL, BLTZAL: begin
                branch   = 1'b1;
                regwrite = 1'b1;
                is_link  = 1'b1;
            end
            J: begin
                jump = 1'b1;
            end
            JAL: begin
                jump     = 1'b1;
                regwrite = 1'b1;
                is_link  = 1'b1;
            end
            JR: begin
                jump = 1'b1;
                jr   = 1'b1;
            end
            JALR: begin
                jump     = 1'b1;
                jr       = 1'b1;
                regwrite = 1'b1;
                is_link  = 1'b1;
            end
            LB, LBU, LH, LHU, LW, LWL, LWR: begin
                regwrite = 1'b1;
                memtoreg = 1'b1;
                alusrc   = IMM;
            end
            SB, SH, SW, SWL, SWR: begin
                memwrite = 1'b1;
                alusrc   = IMM;
            end
            default: ;
        endcase
    end

    // ALU function, shared by register and immediate forms
    always_comb begin
        case (op)
            ADD, ADDI:    alufunc = ALU_ADD;
            ADDU, ADDIU:  alufunc = ALU_ADDU;
            SUB:          alufunc = ALU_SUB;
            SUBU:         alufunc = ALU_SUBU;
            SLT, SLTI:    alufunc = ALU_SLT;
            SLTU, SLTIU:  alufunc = ALU_SLTU;
            AND, ANDI:    alufunc = ALU_AND;
            OR, ORI:      alufunc = ALU_OR;
            XOR, XORI:    alufunc = ALU_XOR;
            NOR:          alufunc = ALU_NOR;
            SLL, SLLV:    alufunc = ALU_SLL;
            SRL, SRLV:    alufunc = ALU_SRL;
            SRA, SRAV:    alufunc = ALU_SRA;
            LUI:          alufunc = ALU_LUI;
            // Jump target comes through on port A
            JR, JALR:     alufunc = ALU_PASSA;
            default:      alufunc = ALU_NONE;
        endcase
    end

    always_comb begin
        case (op)
            BEQ:            branch_type = T_BEQ;
            BNE:            branch_type = T_BNE;
            BGEZ, BGEZAL:   branch_type = T_BGEZ;
            BLTZ, BLTZAL:   branch_type = T_BLTZ;
            BGTZ:           branch_type = T_BGTZ;
            BLEZ:           branch_type = T_BLEZ;
            default:        branch_type = T_NONE;
        endcase
    end

endmodule

// ==== src/operand_select.sv ====
`timescale 1ns/1ns

module operand_select (
    input  mips_pkg::decoded_op_t op,
    input  mips_pkg::word_t       instr,
    output mips_pkg::reg_addr_t   srcrega,
    output mips_pkg::reg_addr_t   srcregb,
    output mips_pkg::reg_addr_t   destreg
);
    import mips_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb begin
        srcrega = '0;
        srcregb = '0;
        destreg = '0;
        case (op)
            ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR,
            SLLV, SRLV, SRAV: begin
                srcrega = rs;
                srcregb = rt;
                destreg = rd;
            end
            // Shift amount comes from the shamt field, rs unused
            SLL, SRL, SRA: begin
                srcregb = rt;
                destreg = rd;
            end
            ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI,
            LB, LBU, LH, LHU, LW, LWL, LWR: begin
                srcrega = rs;
                destreg = rt;
            end
            LUI: destreg = rt;
            BEQ, BNE,
            SB, SH, SW, SWL, SWR: begin
                srcrega = rs;
                srcregb = rt;
            end
            BGEZ, BLTZ, BGTZ, BLEZ, JR: srcrega = rs;
            BGEZAL, BLTZAL, JALR: begin
                srcrega = rs;
                destreg = link_reg;
            end
            JAL: destreg = link_reg;
            default: ;
        endcase
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  mips_pkg::word_t        instr,
    output mips_pkg::decoded_op_t  op,
    output logic                   exception_ri,
    output logic                   regwrite,
    output logic                   memtoreg,
    output logic                   memwrite,
    output logic                   zeroext,
    output logic                   shamt_valid,
    output logic                   branch,
    output logic                   jump,
    output logic                   jr,
    output logic                   is_link,
    output mips_pkg::alu_src_t     alusrc,
    output mips_pkg::alu_func_t    alufunc,
    output mips_pkg::branch_type_t branch_type,
    output mips_pkg::reg_addr_t    srcrega,
    output mips_pkg::reg_addr_t    srcregb,
    output mips_pkg::reg_addr_t    destreg
);
    import mips_pkg::*;

    decoded_op_t  dec_op;
    logic         dec_reserved;
    logic         dec_regwrite;
    logic         dec_memtoreg;
    logic         dec_memwrite;
    logic         dec_zeroext;
    logic         dec_shamt_valid;
    logic         dec_branch;
    logic         dec_jump;
    logic         dec_jr;
    logic         dec_is_link;
    alu_src_t     dec_alusrc;
    alu_func_t    dec_alufunc;
    branch_type_t dec_branch_type;
    reg_addr_t    dec_srcrega;
    reg_addr_t    dec_srcregb;
    reg_addr_t    dec_destreg;

    op_decode op_decode_inst (
        .instr    (instr),
        .op       (dec_op),
        .reserved (dec_reserved)
    );

    control_gen control_gen_inst (
        .op          (dec_op),
        .regwrite    (dec_regwrite),
        .memtoreg    (dec_memtoreg),
        .memwrite    (dec_memwrite),
        .zeroext     (dec_zeroext),
        .shamt_valid (dec_shamt_valid),
        .branch      (dec_branch),
        .jump        (dec_jump),
        .jr          (dec_jr),
        .is_link     (dec_is_link),
        .alusrc      (dec_alusrc),
        .alufunc     (dec_alufunc),
        .branch_type (dec_branch_type)
    );

    operand_select operand_select_inst (
        .op      (dec_op),
        .instr   (instr),
        .srcrega (dec_srcrega),
        .srcregb (dec_srcregb),
        .destreg (dec_destreg)
    );

    // Decode to execute pipeline register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op           <= NOP;
            exception_ri <= 1'b0;
            regwrite     <= 1'b0;
            memtoreg     <= 1'b0;
            memwrite     <= 1'b0;
            zeroext      <= 1'b0;
            shamt_valid  <= 1'b0;
            branch       <= 1'b0;
            jump         <= 1'b0;
            jr           <= 1'b0;
            is_link      <= 1'b0;
            alusrc       <= REGB;
            alufunc      <= ALU_NONE;
            branch_type  <= T_NONE;
            srcrega      <= '0;
            srcregb      <= '0;
            destreg      <= '0;
        end else begin
            op           <= dec_op;
            exception_ri <= dec_reserved;
            regwrite     <= dec_regwrite;
            memtoreg     <= dec_memtoreg;
            memwrite     <= dec_memwrite;
            zeroext      <= dec_zeroext;
            shamt_valid  <= dec_shamt_valid;
            branch       <= dec_branch;
            jump         <= dec_jump;
            jr           <= dec_jr;
            is_link      <= dec_is_link;
            alusrc       <= dec_alusrc;
            alufunc      <= dec_alufunc;
            branch_type  <= dec_branch_type;
            srcrega      <= dec_srcrega;
            srcregb      <= dec_srcregb;
            destreg      <= dec_destreg;
        end
    end

endmodule

// ==== bench/decode_assertions.sv ====
`timescale 1ns/1ns

module decode_assertions (
    input logic                clk,
    input logic                arst_n,
    input logic                exception_ri,
    input logic                regwrite,
    input logic                memtoreg,
    input logic                memwrite,
    input logic                zeroext,
    input logic                shamt_valid,
    input logic                branch,
    input logic                jump,
    input logic                jr,
    input logic                is_link,
    input mips_pkg::reg_addr_t destreg
);
    import mips_pkg::*;

    int failures = 0;

    no_enable_on_reserved: assert property (@(posedge clk) disable iff (!arst_n)
        exception_ri |-> !(regwrite || memtoreg || memwrite || zeroext || shamt_valid
                           || branch || jump || jr || is_link))
        else begin
            $error("reserved instruction left an enable set");
            failures++;
        end

    // A store never writes the register file
    no_reg_and_mem_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(regwrite && memwrite))
        else begin
            $error("regwrite and memwrite both set");
            failures++;
        end

    link_targets_r31: assert property (@(posedge clk) disable iff (!arst_n)
        is_link |-> (destreg == link_reg))
        else begin
            $error("link instruction with destreg other than r31");
            failures++;
        end

    no_branch_and_jump: assert property (@(posedge clk) disable iff (!arst_n)
        !(branch && jump))
        else begin
            $error("branch and jump both set");
            failures++;
        end

endmodule

bind decode_stage decode_assertions decode_assertions_inst (.*);

// ==== bench/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected decode result, one field per DUT output
typedef struct packed {
    decoded_op_t  op;
    logic         exception_ri;
    logic         regwrite;
    logic         memtoreg;
    logic         memwrite;
    logic         zeroext;
    logic         shamt_valid;
    logic         branch;
    logic         jump;
    logic         jr;
    logic         is_link;
    alu_src_t     alusrc;
    alu_func_t    alufunc;
    branch_type_t branch_type;
    reg_addr_t    srcrega;
    reg_addr_t    srcregb;
    reg_addr_t    destreg;
} dec_result_t;

// Operation from the raw MIPS32 field values
function automatic decoded_op_t expected_op(input word_t w);
    decoded_op_t dop;
    dop = RESERVED;
    case (w[31:26])
        6'h00: begin
            case (w[5:0])
                6'h00: dop = SLL;
                6'h02: dop = SRL;
                6'h03: dop = SRA;
                6'h04: dop = SLLV;
                6'h06: dop = SRLV;
                6'h07: dop = SRAV;
                6'h08: dop = JR;
                6'h09: dop = JALR;
                6'h0f: dop = NOP;
                6'h20: dop = ADD;
                6'h21: dop = ADDU;
                6'h22: dop = SUB;
                6'h23: dop = SUBU;
                6'h24: dop = AND;
                6'h25: dop = OR;
                6'h26: dop = XOR;
                6'h27: dop = NOR;
                6'h2a: dop = SLT;
                6'h2b: dop = SLTU;
                default: dop = RESERVED;
            endcase
        end
        6'h01: begin
            case (w[20:16])
                5'h00: dop = BLTZ;
                5'h01: dop = BGEZ;
                5'h10: dop = BLTZAL;
                5'h11: dop = BGEZAL;
                default: dop = RESERVED;
            endcase
        end
        6'h02: dop = J;
        6'h03: dop = JAL;
        6'h04: dop = BEQ;
        6'h05: dop = BNE;
        6'h06: dop = BLEZ;
        6'h07: dop = BGTZ;
        6'h08: dop = ADDI;
        6'h09: dop = ADDIU;
        6'h0a: dop = SLTI;
        6'h0b: dop = SLTIU;
        6'h0c: dop = ANDI;
        6'h0d: dop = ORI;
        6'h0e: dop = XORI;
        6'h0f: dop = LUI;
        6'h20: dop = LB;
        6'h21: dop = LH;
        6'h22: dop = LWL;
        6'h23: dop = LW;
        6'h24: dop = LBU;
        6'h25: dop = LHU;
        6'h26: dop = LWR;
        6'h28: dop = SB;
        6'h29: dop = SH;
        6'h2a: dop = SWL;
        6'h2b: dop = SW;
        6'h2e: dop = SWR;
        // LL and SC act as plain word accesses, PREF as a hint
        6'h30: dop = LW;
        6'h38: dop = SW;
        6'h33: dop = NOP;
        default: dop = RESERVED;
    endcase
    return dop;
endfunction

function automatic dec_result_t decode_model(input word_t w);
    dec_result_t e;
    decoded_op_t dop;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic        shift_imm;
    e  = '0;
    rs = w[25:21];
    rt = w[20:16];
    rd = w[15:11];
    dop = expected_op(w);
    e.op = dop;
    e.exception_ri = (dop == RESERVED);
    case (dop)
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
            shift_imm = (dop == SLL) || (dop == SRL) || (dop == SRA);
            e.regwrite    = 1'b1;
            e.shamt_valid = shift_imm;
            e.srcrega     = shift_imm ? 5'd0 : rs;
            e.srcregb     = rt;
            e.destreg     = rd;
        end
        ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI: begin
            e.regwrite = 1'b1;
            e.alusrc   = IMM;
            e.zeroext  = (dop == ANDI) || (dop == ORI) || (dop == XORI);
            e.srcrega  = (dop == LUI) ? 5'd0 : rs;
            e.destreg  = rt;
        end
        BEQ, BNE, BGEZ, BLTZ, BGTZ, BLEZ, BGEZAL, BLTZAL: begin
            e.branch  = 1'b1;
            e.is_link = (dop == BGEZAL) || (dop == BLTZAL);
            e.srcrega = rs;
            if ((dop == BEQ) || (dop == BNE)) begin
                e.srcregb = rt;
            end
        end
        J, JAL, JR, JALR: begin
            e.jump    = 1'b1;
            e.jr      = (dop == JR) || (dop == JALR);
            e.is_link = (dop == JAL) || (dop == JALR);
            if (e.jr) begin
                e.srcrega = rs;
                e.alufunc = ALU_PASSA;
            end
        end
        LB, LBU, LH, LHU, LW, LWL, LWR: begin
            e.regwrite = 1'b1;
            e.memtoreg = 1'b1;
            e.alusrc   = IMM;
            e.srcrega  = rs;
            e.destreg  = rt;
        end
        SB, SH, SW, SWL, SWR: begin
            e.memwrite = 1'b1;
            e.alusrc   = IMM;
            e.srcrega  = rs;
            e.srcregb  = rt;
        end
        default: ;
    endcase
    // Link forms write the return address to r31
    if (e.is_link) begin
        e.regwrite = 1'b1;
        e.destreg  = link_reg;
    end
    case (dop)
        ADD, ADDI: e.alufunc = ALU_ADD;
        ADDU, ADDIU: e.alufunc = ALU_ADDU;
        SUB: e.alufunc = ALU_SUB;
        SUBU: e.alufunc = ALU_SUBU;
        SLT, SLTI: e.alufunc = ALU_SLT;
        SLTU, SLTIU: e.alufunc = ALU_SLTU;
        AND, ANDI: e.alufunc = ALU_AND;
        OR, ORI: e.alufunc = ALU_OR;
        XOR, XORI: e.alufunc = ALU_XOR;
        NOR: e.alufunc = ALU_NOR;
        SLL, SLLV: e.alufunc = ALU_SLL;
        SRL, SRLV: e.alufunc = ALU_SRL;
        SRA, SRAV: e.alufunc = ALU_SRA;
        LUI: e.alufunc = ALU_LUI;
        default: ;
    endcase
    case (dop)
        BEQ: e.branch_type = T_BEQ;
        BNE: e.branch_type = T_BNE;
        BGEZ, BGEZAL: e.branch_type = T_BGEZ;
        BLTZ, BLTZAL: e.branch_type = T_BLTZ;
        BGTZ: e.branch_type = T_BGTZ;
        BLEZ: e.branch_type = T_BLEZ;
        default: ;
    endcase
    return e;
endfunction

`endif

// ==== bench/tb_decode_stage.sv ====
`timescale 1ns/1ns

module tb_decode_stage;
    import mips_pkg::*;

    `include "decode_model.svh"

    localparam int num_instr  = 3000;
    localparam int wait_limit = 20;

    // Every kept primary opcode, then SPECIAL2, COP0 and CACHE
    localparam int n_opcodes = 34;
    localparam logic [n_opcodes*6-1:0] opcode_list = {
        6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
        6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
        6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e, 6'h30, 6'h33, 6'h38,
        6'h1c, 6'h10, 6'h2f
    };
    // Kept functions, then MOVZ, MOVN, SYSCALL, BREAK, MFHI, MULT, DIV, one unused
    localparam int n_functs = 27;
    localparam logic [n_functs*6-1:0] funct_list = {
        6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0f,
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
        6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h10, 6'h18, 6'h1a, 6'h3f
    };
    // Four branch codes, then four unused or trap codes
    localparam logic [8*5-1:0] regimm_list = {
        5'h00, 5'h01, 5'h10, 5'h11, 5'h02, 5'h03, 5'h0c, 5'h1f
    };

    logic         clk;
    logic         arst_n;
    word_t        instr;
    decoded_op_t  op;
    logic         exception_ri;
    logic         regwrite;
    logic         memtoreg;
    logic         memwrite;
    logic         zeroext;
    logic         shamt_valid;
    logic         branch;
    logic         jump;
    logic         jr;
    logic         is_link;
    alu_src_t     alusrc;
    alu_func_t    alufunc;
    branch_type_t branch_type;
    reg_addr_t    srcrega;
    reg_addr_t    srcregb;
    reg_addr_t    destreg;

    logic [31:0] lfsr_state;
    word_t       applied_q[$];
    int          checks = 0;
    int          value_errors = 0;
    int          timeouts = 0;

    decode_stage decode_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic make_instr(output word_t w);
        logic [31:0] kind;
        logic [31:0] idx;
        logic [31:0] fields;
        logic [5:0]  opc;
        take_bits(2, kind);
        take_bits(6, idx);
        opc = opcode_list[(idx % n_opcodes) * 6 +: 6];
        // Extra weight on SPECIAL, it holds most operations
        if (kind[1:0] == 2'b00) begin
            opc = 6'h00;
        end
        take_bits(26, fields);
        w = {opc, fields[25:0]};
        take_bits(5, idx);
        if (opc == 6'h00) begin
            w[5:0] = funct_list[(idx % n_functs) * 6 +: 6];
        end
        take_bits(3, idx);
        if (opc == 6'h01) begin
            w[20:16] = regimm_list[idx[2:0] * 5 +: 5];
        end
    endtask

    task automatic compare_field(input string name, input word_t w,
                                 input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("error at %0t ns: %s expected %0h got %0h (instr %08h)",
                     $time, name, exp_v, act_v, w);
            value_errors++;
        end
    endtask

    task automatic check_outputs(input dec_result_t e, input word_t w);
        checks++;
        compare_field("op", w, e.op, op);
        compare_field("exception_ri", w, e.exception_ri, exception_ri);
        compare_field("regwrite", w, e.regwrite, regwrite);
        compare_field("memtoreg", w, e.memtoreg, memtoreg);
        compare_field("memwrite", w, e.memwrite, memwrite);
        compare_field("zeroext", w, e.zeroext, zeroext);
        compare_field("shamt_valid", w, e.shamt_valid, shamt_valid);
        compare_field("branch", w, e.branch, branch);
        compare_field("jump", w, e.jump, jump);
        compare_field("jr", w, e.jr, jr);
        compare_field("is_link", w, e.is_link, is_link);
        compare_field("alusrc", w, e.alusrc, alusrc);
        compare_field("alufunc", w, e.alufunc, alufunc);
        compare_field("branch_type", w, e.branch_type, branch_type);
        compare_field("srcrega", w, e.srcrega, srcrega);
        compare_field("srcregb", w, e.srcregb, srcregb);
        compare_field("destreg", w, e.destreg, destreg);
    endtask

    // Stimulus
    initial begin
        word_t w;
        lfsr_state = 32'h95b7d8de;
        arst_n     = 1'b0;
        // add $9, $10, $11 so a register that ignores reset shows up
        instr      = 32'h014b4820;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < num_instr; n++) begin
            make_instr(w);
            instr <= w;
            applied_q.push_back(w);
            @(posedge clk);
        end
    end

    // Compare, one cycle after each instruction is applied
    initial begin
        word_t w;
        int    wait_cycles;
        int    assert_fails;
        // Cleared through reset and up to the first capturing edge
        repeat (16) begin
            @(negedge clk);
            check_outputs('0, instr);
        end
        for (int n = 0; n < num_instr; n++) begin
            wait_cycles = 0;
            while (applied_q.size() == 0 && wait_cycles < wait_limit) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (applied_q.size() == 0) begin
                $display("timeout: no instruction applied within %0d cycles", wait_limit);
                timeouts++;
                break;
            end
            w = applied_q.pop_front();
            @(negedge clk);
            check_outputs(decode_model(w), w);
        end
        assert_fails = decode_stage_inst.decode_assertions_inst.failures;
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checks, value_errors, timeouts, assert_fails);
        if (value_errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+bench
src/mips_pkg.sv
src/op_decode.sv
src/control_gen.sv
src/operand_select.sv
src/decode_stage.sv
bench/decode_assertions.sv
bench/tb_decode_stage.sv
